//--- verilog/spin_pkg.sv
// shared sizes, run configuration struct and vector types
// stage state encodings for the analog spin wrapper
package spin_pkg;

    // array geometry
    localparam int NUM_SPIN = 16;
    localparam int BITDATA = 4;
    // spin value position inside its bit-line group stays below BITDATA
    localparam int SPIN_WBL_OFFSET = 0;

    // cycle counters
    localparam int COUNTER_BITWIDTH = 16;

    // spin output synchronizer
    localparam int SYNC_MAX_STAGES = 3;
    localparam int SYNC_SEL_WIDTH = 2;

    typedef logic [NUM_SPIN-1:0] spin_vec_t;
    typedef logic [NUM_SPIN*BITDATA-1:0] wbl_vec_t;
    typedef logic [COUNTER_BITWIDTH-1:0] cycle_cnt_t;
    typedef logic [SYNC_SEL_WIDTH-1:0] sync_sel_t;

    // run configuration loaded with one strobe
    typedef struct packed {
        cycle_cnt_t write_cycles;
        cycle_cnt_t compute_cycles;
        sync_sel_t  sync_depth;
        spin_vec_t  wwl_strobe;
        spin_vec_t  feedback_mask;
    } spin_cfg_t;

    typedef enum logic {
        WR_IDLE,
        WR_PULSE
    } write_state_e;

    typedef enum logic {
        CMP_IDLE,
        CMP_RUN
    } compute_state_e;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_SYNC,
        CAP_VALID
    } capture_state_e;

endpackage

//--- verilog/spin_pop_stage.sv
// spin pop stage
// accepts one spin vector and holds it until the result is handed off
`timescale 1ns/1ps

module spin_pop_stage (
    input  logic                clk_i,
    input  logic                reset_i,
    // digital side
    input  logic                spin_pop_valid_i,
    input  spin_pkg::spin_vec_t spin_pop_i,
    output logic                spin_pop_ready_o,
    // result handshake seen by the capture stage
    input  logic                result_taken_i,
    // towards the write stage
    output logic                write_start_o,
    output spin_pkg::spin_vec_t spin_o,
    // status
    output logic                rx_idle_o
);

    logic                busy_q;
    logic                write_start_q;
    logic                pop_fire;
    spin_pkg::spin_vec_t spin_q;

    // only one spin in flight
    assign spin_pop_ready_o = ~busy_q;
    assign pop_fire = spin_pop_valid_i & spin_pop_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            write_start_q <= 1'b0;
        end else begin
            write_start_q <= pop_fire;
            if (pop_fire) begin
                busy_q <= 1'b1;
            end else if (result_taken_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // held for the write stage until the next pop
    always_ff @(posedge clk_i) begin
        if (pop_fire) begin
            spin_q <= spin_pop_i;
        end
    end

    assign write_start_o = write_start_q;
    assign spin_o = spin_q;
    assign rx_idle_o = ~busy_q;

endmodule

//--- verilog/spin_write_stage.sv
// spin write stage
// pulses the word lines with the strobe mask and drives the
// expanded spin on the bit lines for the write window
`timescale 1ns/1ps

module spin_write_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // configuration
    input  logic                  cfg_load_i,
    input  spin_pkg::spin_cfg_t   cfg_i,
    // from the pop stage
    input  logic                  write_start_i,
    input  spin_pkg::spin_vec_t   spin_i,
    // towards the analog macro
    output spin_pkg::spin_vec_t   spin_wwl_o,
    output spin_pkg::wbl_vec_t    wbl_o,
    // towards the compute stage
    output logic                  write_done_o
);

    spin_pkg::cycle_cnt_t   write_cycles_q;
    spin_pkg::spin_vec_t    wwl_strobe_q;
    spin_pkg::write_state_e state_q;
    spin_pkg::cycle_cnt_t   cnt_q;
    spin_pkg::cycle_cnt_t   cnt_load;
    spin_pkg::wbl_vec_t     wbl_spin;
    logic                   pulse_active;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            write_cycles_q <= '0;
            wwl_strobe_q <= '0;
        end else if (cfg_load_i) begin
            write_cycles_q <= cfg_i.write_cycles;
            wwl_strobe_q <= cfg_i.wwl_strobe;
        end
    end

    // a zero setting still gives a one cycle pulse
    assign cnt_load = (write_cycles_q == '0) ? '0 : write_cycles_q - spin_pkg::cycle_cnt_t'(1);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= spin_pkg::WR_IDLE;
            cnt_q <= '0;
        end else begin
            case (state_q)
                spin_pkg::WR_IDLE: begin
                    if (write_start_i) begin
                        state_q <= spin_pkg::WR_PULSE;
                        cnt_q <= cnt_load;
                    end
                end
                default: begin
                    if (cnt_q == '0) begin
                        state_q <= spin_pkg::WR_IDLE;
                    end else begin
                        cnt_q <= cnt_q - spin_pkg::cycle_cnt_t'(1);
                    end
                end
            endcase
        end
    end

    // one spin bit per bit-line group with the rest of the group low
    for (genvar i = 0; i < spin_pkg::NUM_SPIN; i++) begin : gen_wbl_expand
        assign wbl_spin[i*spin_pkg::BITDATA +: spin_pkg::BITDATA] =
            spin_pkg::BITDATA'(spin_i[i]) << spin_pkg::SPIN_WBL_OFFSET;
    end

    assign pulse_active = (state_q == spin_pkg::WR_PULSE);
    assign spin_wwl_o = pulse_active ? wwl_strobe_q : '0;
    assign wbl_o = pulse_active ? wbl_spin : '0;
    assign write_done_o = pulse_active && (cnt_q == '0);

endmodule

//--- verilog/spin_compute_stage.sv
// spin compute stage
// holds the feedback enables for the compute window
`timescale 1ns/1ps

module spin_compute_stage (
    input  logic                clk_i,
    input  logic                reset_i,
    // configuration
    input  logic                cfg_load_i,
    input  spin_pkg::spin_cfg_t cfg_i,
    // from the write stage
    input  logic                write_done_i,
    // towards the analog macro
    output spin_pkg::spin_vec_t spin_feedback_o,
    // towards the capture stage
    output logic                compute_done_o
);

    spin_pkg::cycle_cnt_t     compute_cycles_q;
    spin_pkg::spin_vec_t      feedback_mask_q;
    spin_pkg::compute_state_e state_q;
    spin_pkg::cycle_cnt_t     cnt_q;
    logic                     run_active;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            compute_cycles_q <= '0;
            feedback_mask_q <= '0;
        end else if (cfg_load_i) begin
            compute_cycles_q <= cfg_i.compute_cycles;
            feedback_mask_q <= cfg_i.feedback_mask;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= spin_pkg::CMP_IDLE;
            cnt_q <= '0;
        end else if (state_q == spin_pkg::CMP_IDLE) begin
            if (write_done_i) begin
                state_q <= spin_pkg::CMP_RUN;
                // at least one compute cycle
                cnt_q <= (compute_cycles_q == '0) ? '0 :
                         compute_cycles_q - spin_pkg::cycle_cnt_t'(1);
            end
        end else if (cnt_q == '0) begin
            state_q <= spin_pkg::CMP_IDLE;
        end else begin
            cnt_q <= cnt_q - spin_pkg::cycle_cnt_t'(1);
        end
    end

    assign run_active = (state_q == spin_pkg::CMP_RUN);
    assign spin_feedback_o = run_active ? feedback_mask_q : '0;
    assign compute_done_o = run_active && (cnt_q == '0);

endmodule

//--- verilog/spin_capture_stage.sv
// spin capture stage
// samples the macro spin outputs through a selectable synchronizer
// and offers the result with valid/ready
`timescale 1ns/1ps

module spin_capture_stage (
    input  logic                clk_i,
    input  logic                reset_i,
    // configuration
    input  logic                cfg_load_i,
    input  spin_pkg::spin_cfg_t cfg_i,
    // from the compute stage
    input  logic                compute_done_i,
    // from the analog macro
    input  spin_pkg::spin_vec_t spin_analog_i,
    // digital side
    output logic                spin_valid_o,
    input  logic                spin_ready_i,
    output spin_pkg::spin_vec_t spin_o,
    // towards the pop stage
    output logic                result_taken_o,
    // status
    output logic                tx_idle_o
);

    spin_pkg::sync_sel_t      sync_depth_q;
    spin_pkg::capture_state_e state_q;
    spin_pkg::sync_sel_t      cnt_q;
    spin_pkg::spin_vec_t      sync_q [spin_pkg::SYNC_MAX_STAGES];
    spin_pkg::spin_vec_t      sync_sel;
    spin_pkg::spin_vec_t      result_q;
    logic                     sync_last;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sync_depth_q <= '0;
        end else if (cfg_load_i) begin
            sync_depth_q <= cfg_i.sync_depth;
        end
    end

    // depth zero takes the macro output directly as the final stage
    assign sync_sel = (sync_depth_q == '0) ? spin_analog_i : sync_q[sync_depth_q - 1'b1];
    assign sync_last = (state_q == spin_pkg::CAP_SYNC) && (cnt_q == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= spin_pkg::CAP_IDLE;
            cnt_q <= '0;
        end else begin
            case (state_q)
                spin_pkg::CAP_IDLE: begin
                    if (compute_done_i) begin
                        state_q <= spin_pkg::CAP_SYNC;
                        cnt_q <= sync_depth_q;
                    end
                end
                spin_pkg::CAP_SYNC: begin
                    if (cnt_q == '0) begin
                        state_q <= spin_pkg::CAP_VALID;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    if (spin_ready_i) begin
                        state_q <= spin_pkg::CAP_IDLE;
                    end
                end
            endcase
        end
    end

    // chain only shifts while synchronizing
    always_ff @(posedge clk_i) begin
        if (state_q == spin_pkg::CAP_SYNC) begin
            sync_q[0] <= spin_analog_i;
            for (int i = 1; i < spin_pkg::SYNC_MAX_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // result holds until the handshake
    always_ff @(posedge clk_i) begin
        if (sync_last) begin
            result_q <= sync_sel;
        end
    end

    assign spin_valid_o = (state_q == spin_pkg::CAP_VALID);
    assign spin_o = result_q;
    assign result_taken_o = spin_valid_o & spin_ready_i;
    assign tx_idle_o = (state_q == spin_pkg::CAP_IDLE);

endmodule

//--- verilog/analog_spin_wrap.sv
// analog macro wrapper for the regular spin path
// pop, write, compute and capture stages chained by pulses
`timescale 1ns/1ps

module analog_spin_wrap (
    input  logic                clk_i,
    input  logic                reset_i,
    // configuration
    input  logic                cfg_load_i,
    input  spin_pkg::spin_cfg_t cfg_i,
    // spin pop from the digital side
    input  logic                spin_pop_valid_i,
    output logic                spin_pop_ready_o,
    input  spin_pkg::spin_vec_t spin_pop_i,
    // analog macro
    output spin_pkg::spin_vec_t spin_wwl_o,
    output spin_pkg::spin_vec_t spin_feedback_o,
    output spin_pkg::wbl_vec_t  wbl_o,
    input  spin_pkg::spin_vec_t spin_analog_i,
    // result to the digital side
    output logic                spin_valid_o,
    input  logic                spin_ready_i,
    output spin_pkg::spin_vec_t spin_o,
    // status
    output logic                analog_rx_idle_o,
    output logic                analog_tx_idle_o
);

    logic                write_start;
    logic                write_done;
    logic                compute_done;
    logic                result_taken;
    spin_pkg::spin_vec_t spin_held;

    spin_pop_stage u_pop (
        .clk_i            (clk_i           ),
        .reset_i          (reset_i         ),
        .spin_pop_valid_i (spin_pop_valid_i),
        .spin_pop_i       (spin_pop_i      ),
        .result_taken_i   (result_taken    ),
        .spin_pop_ready_o (spin_pop_ready_o),
        .write_start_o    (write_start     ),
        .spin_o           (spin_held       ),
        .rx_idle_o        (analog_rx_idle_o)
    );

    spin_write_stage u_write (
        .clk_i            (clk_i           ),
        .reset_i          (reset_i         ),
        .cfg_load_i       (cfg_load_i      ),
        .cfg_i            (cfg_i           ),
        .write_start_i    (write_start     ),
        .spin_i           (spin_held       ),
        .spin_wwl_o       (spin_wwl_o      ),
        .wbl_o            (wbl_o           ),
        .write_done_o     (write_done      )
    );

    spin_compute_stage u_compute (
        .clk_i            (clk_i           ),
        .reset_i          (reset_i         ),
        .cfg_load_i       (cfg_load_i      ),
        .cfg_i            (cfg_i           ),
        .write_done_i     (write_done      ),
        .spin_feedback_o  (spin_feedback_o ),
        .compute_done_o   (compute_done    )
    );

    spin_capture_stage u_capture (
        .clk_i            (clk_i           ),
        .reset_i          (reset_i         ),
        .cfg_load_i       (cfg_load_i      ),
        .cfg_i            (cfg_i           ),
        .compute_done_i   (compute_done    ),
        .spin_analog_i    (spin_analog_i   ),
        .spin_valid_o     (spin_valid_o    ),
        .spin_ready_i     (spin_ready_i    ),
        .spin_o           (spin_o          ),
        .result_taken_o   (result_taken    ),
        .tx_idle_o        (analog_tx_idle_o)
    );

endmodule

//--- test/tb_analog_spin_wrap.sv
// testbench for the analog spin wrapper
// analog macro model, randomized spin traffic and concurrent assertion checks
`timescale 1ns/1ps

module tb_analog_spin_wrap;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_CFG = 3;
    localparam int SPINS_PER_CFG = 12;
    localparam int MAX_GAP = 5;
    // largest W + C + S over the configuration table
    localparam int MAX_STAGE_CYCLES = 8;
    localparam int WATCHDOG_CYCLES =
        NUM_CFG * SPINS_PER_CFG * (MAX_STAGE_CYCLES + 3 + MAX_GAP) + 200;
    localparam logic [31:0] SEED = 32'hf01eefba;

    logic                clk_i;
    logic                reset_i;
    logic                cfg_load_i;
    spin_pkg::spin_cfg_t cfg_i;
    logic                spin_pop_valid_i;
    logic                spin_pop_ready_o;
    spin_pkg::spin_vec_t spin_pop_i;
    spin_pkg::spin_vec_t spin_wwl_o;
    spin_pkg::spin_vec_t spin_feedback_o;
    spin_pkg::wbl_vec_t  wbl_o;
    spin_pkg::spin_vec_t spin_analog_i;
    logic                spin_valid_o;
    logic                spin_ready_i;
    spin_pkg::spin_vec_t spin_o;
    logic                analog_rx_idle_o;
    logic                analog_tx_idle_o;

    int                  errors;
    int                  spins_done;
    logic [31:0]         rng_state;
    spin_pkg::spin_cfg_t cfg_table [NUM_CFG];

    // age counts cycles since the pop transfer of the spin in flight
    spin_pkg::spin_cfg_t cur_cfg;
    logic                active;
    int                  age;
    spin_pkg::spin_vec_t exp_spin;
    int                  w_len;
    int                  c_len;
    int                  s_len;
    logic                in_write;
    logic                in_compute;
    logic                capture_busy;
    logic                result_due;
    spin_pkg::spin_vec_t exp_wwl;
    spin_pkg::wbl_vec_t  exp_wbl;
    spin_pkg::spin_vec_t exp_feedback;
    spin_pkg::spin_vec_t exp_result;

    analog_spin_wrap u_analog_spin_wrap (.*);

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic spin_pkg::wbl_vec_t expand_spin(input spin_pkg::spin_vec_t s);
        spin_pkg::wbl_vec_t w;
        w = '0;
        for (int i = 0; i < spin_pkg::NUM_SPIN; i++) begin
            w[i*spin_pkg::BITDATA + spin_pkg::SPIN_WBL_OFFSET] = s[i];
        end
        return w;
    endfunction

    function automatic spin_pkg::spin_vec_t collect_spin(input spin_pkg::wbl_vec_t w);
        spin_pkg::spin_vec_t s;
        for (int i = 0; i < spin_pkg::NUM_SPIN; i++) begin
            s[i] = w[i*spin_pkg::BITDATA + spin_pkg::SPIN_WBL_OFFSET];
        end
        return s;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        errors++;
        $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    // loads only while every stage is idle
    task automatic load_config(input spin_pkg::spin_cfg_t cfg);
        cfg_load_i <= 1'b1;
        cfg_i <= cfg;
        cur_cfg <= cfg;
        @(posedge clk_i);
        cfg_load_i <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic send_spin(input spin_pkg::spin_vec_t value, input int gap);
        spin_pop_valid_i <= 1'b1;
        spin_pop_i <= value;
        @(posedge clk_i);
        while (!spin_pop_ready_o) begin
            @(posedge clk_i);
        end
        spin_pop_valid_i <= 1'b0;
        while (!spin_valid_o) begin
            @(posedge clk_i);
        end
        // hold the result back for a while
        repeat (gap) @(posedge clk_i);
        spin_ready_i <= 1'b1;
        @(posedge clk_i);
        spin_ready_i <= 1'b0;
        spins_done++;
    endtask

    // macro model keeps the last written spin with feedback applied
    always @(posedge clk_i) begin
        if (spin_wwl_o != '0) begin
            spin_analog_i <= collect_spin(wbl_o) ^ cur_cfg.feedback_mask;
        end
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            active <= 1'b0;
            age <= 0;
        end else if (spin_pop_valid_i && spin_pop_ready_o) begin
            active <= 1'b1;
            age <= 1;
            exp_spin <= spin_pop_i;
        end else if (active) begin
            age <= age + 1;
            if (spin_valid_o && spin_ready_i) begin
                active <= 1'b0;
            end
        end
    end

    assign w_len = (cur_cfg.write_cycles == '0) ? 1 : int'(cur_cfg.write_cycles);
    assign c_len = (cur_cfg.compute_cycles == '0) ? 1 : int'(cur_cfg.compute_cycles);
    assign s_len = int'(cur_cfg.sync_depth);
    assign in_write = active && (age >= 2) && (age < 2 + w_len);
    assign in_compute = active && (age >= 2 + w_len) && (age < 2 + w_len + c_len);
    assign capture_busy = active && (age >= 2 + w_len + c_len);
    assign result_due = active && (age >= 3 + w_len + c_len + s_len);
    assign exp_wwl = in_write ? cur_cfg.wwl_strobe : '0;
    assign exp_wbl = in_write ? expand_spin(exp_spin) : '0;
    assign exp_feedback = in_compute ? cur_cfg.feedback_mask : '0;
    assign exp_result = exp_spin ^ cur_cfg.feedback_mask;

    check_reset: assert property (@(posedge clk_i) reset_i |=>
        (spin_valid_o == 1'b0) && (spin_wwl_o == '0) && (spin_feedback_o == '0) &&
        (wbl_o == '0) && spin_pop_ready_o && analog_rx_idle_o && analog_tx_idle_o)
        else report_failure("outputs are not at their reset values after reset");
    check_wwl: assert property (@(posedge clk_i) disable iff (reset_i)
        spin_wwl_o == exp_wwl)
        else report_value("spin_wwl_o", $sampled(spin_wwl_o), $sampled(exp_wwl));
    check_wbl: assert property (@(posedge clk_i) disable iff (reset_i)
        wbl_o == exp_wbl)
        else report_value("wbl_o", $sampled(wbl_o), $sampled(exp_wbl));
    check_feedback: assert property (@(posedge clk_i) disable iff (reset_i)
        spin_feedback_o == exp_feedback)
        else report_value("spin_feedback_o", $sampled(spin_feedback_o),
                          $sampled(exp_feedback));
    check_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        spin_valid_o == result_due)
        else report_value("spin_valid_o", $sampled(spin_valid_o), $sampled(result_due));
    check_result: assert property (@(posedge clk_i) disable iff (reset_i)
        spin_valid_o |-> (spin_o == exp_result))
        else report_value("spin_o", $sampled(spin_o), $sampled(exp_result));
    check_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        spin_valid_o && !spin_ready_i |=> spin_valid_o && $stable(spin_o))
        else report_failure("result changed or dropped while spin_ready_i was low");
    check_pop_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        spin_pop_ready_o == !active)
        else report_value("spin_pop_ready_o", $sampled(spin_pop_ready_o), $sampled(!active));
    check_rx_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        analog_rx_idle_o == !active)
        else report_value("analog_rx_idle_o", $sampled(analog_rx_idle_o), $sampled(!active));
    check_tx_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        analog_tx_idle_o == !capture_busy)
        else report_value("analog_tx_idle_o", $sampled(analog_tx_idle_o),
                          $sampled(!capture_busy));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all spins were handed off");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        spin_pkg::spin_vec_t value;
        int                  gap;
        reset_i = 1'b1;
        cfg_load_i = 1'b0;
        cfg_i = '0;
        spin_pop_valid_i = 1'b0;
        spin_pop_i = '0;
        spin_analog_i = '0;
        spin_ready_i = 1'b0;
        errors = 0;
        spins_done = 0;
        rng_state = SEED;
        cur_cfg = '0;
        // second and third entries reload with new depth, strobe and write time
        cfg_table[0] = '{write_cycles: 16'd3, compute_cycles: 16'd2, sync_depth: 2'd2,
                         wwl_strobe: 16'hffff, feedback_mask: 16'h00f0};
        cfg_table[1] = '{write_cycles: 16'd0, compute_cycles: 16'd4, sync_depth: 2'd0,
                         wwl_strobe: 16'h5a5a, feedback_mask: 16'h8001};
        cfg_table[2] = '{write_cycles: 16'd4, compute_cycles: 16'd0, sync_depth: 2'd3,
                         wwl_strobe: 16'h0ff0, feedback_mask: 16'hffff};
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);
        for (int k = 0; k < NUM_CFG; k++) begin
            load_config(cfg_table[k]);
            for (int n = 0; n < SPINS_PER_CFG; n++) begin
                rng_state = lcg_next(rng_state);
                value = rng_state[31:16];
                rng_state = lcg_next(rng_state);
                gap = int'(rng_state[31:24]) % (MAX_GAP + 1);
                send_spin(value, gap);
            end
        end
        repeat (4) @(posedge clk_i);
        $display("spins handed off: %0d, errors: %0d", spins_done, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/spin_pkg.sv
verilog/spin_pop_stage.sv
verilog/spin_write_stage.sv
verilog/spin_compute_stage.sv
verilog/spin_capture_stage.sv
verilog/analog_spin_wrap.sv
test/tb_analog_spin_wrap.sv

//--- Bender.yml
package:
  name: analog_spin_wrap

sources:
  - files:
      - verilog/spin_pkg.sv
      - verilog/spin_pop_stage.sv
      - verilog/spin_write_stage.sv
      - verilog/spin_compute_stage.sv
      - verilog/spin_capture_stage.sv
      - verilog/analog_spin_wrap.sv
  - target: test
    files:
      - test/tb_analog_spin_wrap.sv
